// File: logic/mem_stats_pkg.sv
package mem_stats_pkg;

   // Command channel
   localparam int ADDR_W     = 32;
   localparam int BTT_W      = 23;
   localparam int CMD_W      = 72;                  // Data mover command word

   // Data stream, 512-bit beats
   localparam int KEEP_W     = 64;
   localparam int KEEP_GRAIN = 8;                   // Keep comes in whole 8-byte groups

   // Counters and register port
   localparam int CNT_W      = 32;
   localparam int LEN_CNT_W  = 48;
   localparam int STS_W      = 8;
   localparam int REG_ADDR_W = 4;
   localparam int REG_W      = LEN_CNT_W;

   // Register map, write path in the low half, read path in the high half
   localparam logic [REG_ADDR_W-1:0] REG_WR_CMD     = 4'd0;
   localparam logic [REG_ADDR_W-1:0] REG_WR_WORD    = 4'd1;
   localparam logic [REG_ADDR_W-1:0] REG_WR_PKG     = 4'd2;
   localparam logic [REG_ADDR_W-1:0] REG_WR_LEN     = 4'd3;
   localparam logic [REG_ADDR_W-1:0] REG_WR_STS     = 4'd4;
   localparam logic [REG_ADDR_W-1:0] REG_WR_STS_ERR = 4'd5;
   localparam logic [REG_ADDR_W-1:0] REG_RD_CMD     = 4'd8;
   localparam logic [REG_ADDR_W-1:0] REG_RD_WORD    = 4'd9;
   localparam logic [REG_ADDR_W-1:0] REG_RD_PKG     = 4'd10;
   localparam logic [REG_ADDR_W-1:0] REG_RD_LEN     = 4'd11;
   localparam logic [REG_ADDR_W-1:0] REG_RD_STS     = 4'd12;
   localparam logic [REG_ADDR_W-1:0] REG_RD_STS_ERR = 4'd13;

   // Status byte from the data mover
   typedef struct packed {
      logic       okay;                             // Transfer completed without error
      logic       slverr;
      logic       decerr;
      logic       interr;
      logic [3:0] tag;                              // Echo of the command tag
   } mem_status_fields_t;

   typedef union packed {
      logic [STS_W-1:0]   raw;
      mem_status_fields_t fields;
   } mem_status_t;

endpackage

// File: logic/mem_cmd_formatter.sv
`timescale 1ns/1ps

module mem_cmd_formatter
   import mem_stats_pkg::*;
(
   input  logic              mem_clk,
   input  logic              mem_aresetn,

   // User side
   input  logic              cmd_valid,
   output logic              cmd_ready,
   input  logic [ADDR_W-1:0] cmd_addr,
   input  logic [BTT_W-1:0]  cmd_len,

   // Data mover side
   output logic              dm_cmd_valid,
   input  logic              dm_cmd_ready,
   output logic [CMD_W-1:0]  dm_cmd_data,

   output logic [CNT_W-1:0]  cmd_count
);

   logic cmd_fire;

   // Handshake passes straight through, no buffering
   assign dm_cmd_valid = cmd_valid;
   assign cmd_ready    = dm_cmd_ready;
   assign cmd_fire     = cmd_valid & dm_cmd_ready;

   // Word layout, MSB first: rsvd/tag, address, drr, eof, dsa, type, btt
   assign dm_cmd_data = {
      8'h00,                                        // Reserved and tag
      cmd_addr,
      1'b1,                                         // drr
      1'b1,                                         // eof
      6'h00,                                        // dsa
      1'b1,                                         // Incrementing burst
      cmd_len
   };

   always_ff @(posedge mem_clk) begin
      if (!mem_aresetn) begin
         cmd_count <= '0;
      end else if (cmd_fire) begin
         cmd_count <= cmd_count + 1'b1;             // Accepted commands only
      end
   end

endmodule

// File: logic/mem_stream_meter.sv
`timescale 1ns/1ps

module mem_stream_meter
   import mem_stats_pkg::*;
(
   input  logic                 mem_clk,
   input  logic                 mem_aresetn,

   // Observed stream handshake and framing
   input  logic                 beat_valid,
   input  logic                 beat_ready,
   input  logic [KEEP_W-1:0]    beat_keep,
   input  logic                 beat_last,

   output logic [CNT_W-1:0]     word_count,
   output logic [CNT_W-1:0]     pkg_count,
   output logic [LEN_CNT_W-1:0] byte_count
);

   logic                 beat_fire;
   logic [LEN_CNT_W-1:0] beat_bytes;

   assign beat_fire = beat_valid & beat_ready;

   // Only a contiguous run of low keep groups is recognised
   always_comb begin
      beat_bytes = '0;
      for (int k = 1; k <= KEEP_W / KEEP_GRAIN; k++) begin
         if (beat_keep == ({KEEP_W{1'b1}} >> (KEEP_W - k * KEEP_GRAIN))) begin
            beat_bytes = LEN_CNT_W'(k * KEEP_GRAIN);
         end
      end
   end

   always_ff @(posedge mem_clk) begin
      if (!mem_aresetn) begin
         word_count <= '0;
         pkg_count  <= '0;
         byte_count <= '0;
      end else if (beat_fire) begin
         word_count <= word_count + 1'b1;
         byte_count <= byte_count + beat_bytes;     // Odd keep patterns add nothing
         if (beat_last) begin
            pkg_count <= pkg_count + 1'b1;
         end
      end
   end

endmodule

// File: logic/mem_status_tracker.sv
`timescale 1ns/1ps

module mem_status_tracker
   import mem_stats_pkg::*;
(
   input  logic             mem_clk,
   input  logic             mem_aresetn,

   // Observed status channel
   input  logic             sts_valid,
   input  logic             sts_ready,
   input  mem_status_t      sts_data,

   output logic [CNT_W-1:0] sts_count,
   output logic [CNT_W-1:0] sts_err_count
);

   logic sts_fire;
   logic sts_failed;

   assign sts_fire   = sts_valid & sts_ready;
   assign sts_failed = ~sts_data.fields.okay;       // Any error flag clears okay

   always_ff @(posedge mem_clk) begin
      if (!mem_aresetn) begin
         sts_count     <= '0;
         sts_err_count <= '0;
      end else if (sts_fire) begin
         sts_count <= sts_count + 1'b1;
         if (sts_failed) begin
            sts_err_count <= sts_err_count + 1'b1;
         end
      end
   end

endmodule

// File: logic/mem_stats_regs.sv
`timescale 1ns/1ps

module mem_stats_regs
   import mem_stats_pkg::*;
(
   input  logic                  mem_clk,
   input  logic                  mem_aresetn,

   // Read strobe and address
   input  logic                  reg_rd,
   input  logic [REG_ADDR_W-1:0] reg_addr,

   // Write path counters
   input  logic [CNT_W-1:0]      wr_cmd_count,
   input  logic [CNT_W-1:0]      wr_word_count,
   input  logic [CNT_W-1:0]      wr_pkg_count,
   input  logic [LEN_CNT_W-1:0]  wr_byte_count,
   input  logic [CNT_W-1:0]      wr_sts_count,
   input  logic [CNT_W-1:0]      wr_sts_err_count,

   // Read path counters
   input  logic [CNT_W-1:0]      rd_cmd_count,
   input  logic [CNT_W-1:0]      rd_word_count,
   input  logic [CNT_W-1:0]      rd_pkg_count,
   input  logic [LEN_CNT_W-1:0]  rd_byte_count,
   input  logic [CNT_W-1:0]      rd_sts_count,
   input  logic [CNT_W-1:0]      rd_sts_err_count,

   output logic                  reg_rvalid,
   output logic [REG_W-1:0]      reg_rdata
);

   logic [REG_W-1:0] sel_data;

   always_comb begin
      case (reg_addr)
         REG_WR_CMD:     sel_data = REG_W'(wr_cmd_count);
         REG_WR_WORD:    sel_data = REG_W'(wr_word_count);
         REG_WR_PKG:     sel_data = REG_W'(wr_pkg_count);
         REG_WR_LEN:     sel_data = REG_W'(wr_byte_count);
         REG_WR_STS:     sel_data = REG_W'(wr_sts_count);
         REG_WR_STS_ERR: sel_data = REG_W'(wr_sts_err_count);
         REG_RD_CMD:     sel_data = REG_W'(rd_cmd_count);
         REG_RD_WORD:    sel_data = REG_W'(rd_word_count);
         REG_RD_PKG:     sel_data = REG_W'(rd_pkg_count);
         REG_RD_LEN:     sel_data = REG_W'(rd_byte_count);
         REG_RD_STS:     sel_data = REG_W'(rd_sts_count);
         REG_RD_STS_ERR: sel_data = REG_W'(rd_sts_err_count);
         default:        sel_data = '0;             // Holes in the map read as zero
      endcase
   end

   always_ff @(posedge mem_clk) begin
      if (!mem_aresetn) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_rd;                      // One cycle pulse per strobe
      end
   end

   // Snapshot taken at the strobe edge
   always_ff @(posedge mem_clk) begin
      if (reg_rd) begin
         reg_rdata <= sel_data;
      end
   end

endmodule

// File: logic/mem_single_inf.sv
`timescale 1ns/1ps

module mem_single_inf
   import mem_stats_pkg::*;
(
   input  logic                  mem_clk,
   input  logic                  mem_aresetn,

   // Write command
   input  logic                  wr_cmd_valid,
   output logic                  wr_cmd_ready,
   input  logic [ADDR_W-1:0]     wr_cmd_addr,
   input  logic [BTT_W-1:0]      wr_cmd_len,
   output logic                  wr_dm_cmd_valid,
   input  logic                  wr_dm_cmd_ready,
   output logic [CMD_W-1:0]      wr_dm_cmd_data,

   // Read command
   input  logic                  rd_cmd_valid,
   output logic                  rd_cmd_ready,
   input  logic [ADDR_W-1:0]     rd_cmd_addr,
   input  logic [BTT_W-1:0]      rd_cmd_len,
   output logic                  rd_dm_cmd_valid,
   input  logic                  rd_dm_cmd_ready,
   output logic [CMD_W-1:0]      rd_dm_cmd_data,

   // Stream observation
   input  logic                  wr_data_valid,
   input  logic                  wr_data_ready,
   input  logic [KEEP_W-1:0]     wr_data_keep,
   input  logic                  wr_data_last,
   input  logic                  rd_data_valid,
   input  logic                  rd_data_ready,
   input  logic [KEEP_W-1:0]     rd_data_keep,
   input  logic                  rd_data_last,

   // Status observation
   input  logic                  wr_sts_valid,
   input  logic                  wr_sts_ready,
   input  logic [STS_W-1:0]      wr_sts_data,
   input  logic                  rd_sts_valid,
   input  logic                  rd_sts_ready,
   input  logic [STS_W-1:0]      rd_sts_data,

   // Register readout
   input  logic                  reg_rd,
   input  logic [REG_ADDR_W-1:0] reg_addr,
   output logic                  reg_rvalid,
   output logic [REG_W-1:0]      reg_rdata
);

   logic [CNT_W-1:0]     wr_cmd_count,  rd_cmd_count;
   logic [CNT_W-1:0]     wr_word_count, rd_word_count;
   logic [CNT_W-1:0]     wr_pkg_count,  rd_pkg_count;
   logic [LEN_CNT_W-1:0] wr_byte_count, rd_byte_count;
   logic [CNT_W-1:0]     wr_sts_count,  rd_sts_count;
   logic [CNT_W-1:0]     wr_sts_err_count, rd_sts_err_count;

   mem_cmd_formatter u_wr_cmd (
      .mem_clk      (mem_clk),
      .mem_aresetn  (mem_aresetn),
      .cmd_valid    (wr_cmd_valid),
      .cmd_ready    (wr_cmd_ready),
      .cmd_addr     (wr_cmd_addr),
      .cmd_len      (wr_cmd_len),
      .dm_cmd_valid (wr_dm_cmd_valid),
      .dm_cmd_ready (wr_dm_cmd_ready),
      .dm_cmd_data  (wr_dm_cmd_data),
      .cmd_count    (wr_cmd_count)
   );

   mem_cmd_formatter u_rd_cmd (
      .mem_clk      (mem_clk),
      .mem_aresetn  (mem_aresetn),
      .cmd_valid    (rd_cmd_valid),
      .cmd_ready    (rd_cmd_ready),
      .cmd_addr     (rd_cmd_addr),
      .cmd_len      (rd_cmd_len),
      .dm_cmd_valid (rd_dm_cmd_valid),
      .dm_cmd_ready (rd_dm_cmd_ready),
      .dm_cmd_data  (rd_dm_cmd_data),
      .cmd_count    (rd_cmd_count)
   );

   mem_stream_meter u_wr_meter (
      .mem_clk     (mem_clk),
      .mem_aresetn (mem_aresetn),
      .beat_valid  (wr_data_valid),
      .beat_ready  (wr_data_ready),
      .beat_keep   (wr_data_keep),
      .beat_last   (wr_data_last),
      .word_count  (wr_word_count),
      .pkg_count   (wr_pkg_count),
      .byte_count  (wr_byte_count)
   );

   mem_stream_meter u_rd_meter (
      .mem_clk     (mem_clk),
      .mem_aresetn (mem_aresetn),
      .beat_valid  (rd_data_valid),
      .beat_ready  (rd_data_ready),
      .beat_keep   (rd_data_keep),
      .beat_last   (rd_data_last),
      .word_count  (rd_word_count),
      .pkg_count   (rd_pkg_count),
      .byte_count  (rd_byte_count)
   );

   mem_status_tracker u_wr_sts (
      .mem_clk       (mem_clk),
      .mem_aresetn   (mem_aresetn),
      .sts_valid     (wr_sts_valid),
      .sts_ready     (wr_sts_ready),
      .sts_data      (wr_sts_data),                 // Raw byte, decoded inside
      .sts_count     (wr_sts_count),
      .sts_err_count (wr_sts_err_count)
   );

   mem_status_tracker u_rd_sts (
      .mem_clk       (mem_clk),
      .mem_aresetn   (mem_aresetn),
      .sts_valid     (rd_sts_valid),
      .sts_ready     (rd_sts_ready),
      .sts_data      (rd_sts_data),
      .sts_count     (rd_sts_count),
      .sts_err_count (rd_sts_err_count)
   );

   mem_stats_regs u_regs (
      .mem_clk          (mem_clk),
      .mem_aresetn      (mem_aresetn),
      .reg_rd           (reg_rd),
      .reg_addr         (reg_addr),
      .wr_cmd_count     (wr_cmd_count),
      .wr_word_count    (wr_word_count),
      .wr_pkg_count     (wr_pkg_count),
      .wr_byte_count    (wr_byte_count),
      .wr_sts_count     (wr_sts_count),
      .wr_sts_err_count (wr_sts_err_count),
      .rd_cmd_count     (rd_cmd_count),
      .rd_word_count    (rd_word_count),
      .rd_pkg_count     (rd_pkg_count),
      .rd_byte_count    (rd_byte_count),
      .rd_sts_count     (rd_sts_count),
      .rd_sts_err_count (rd_sts_err_count),
      .reg_rvalid       (reg_rvalid),
      .reg_rdata        (reg_rdata)
   );

endmodule

// File: tests/mem_single_inf_asserts.sv
`timescale 1ns/1ps

module mem_single_inf_asserts (
   input logic mem_clk,
   input logic mem_aresetn,
   input logic reg_rd,
   input logic reg_rvalid,
   input logic wr_cmd_valid,
   input logic wr_dm_cmd_valid,
   input logic rd_cmd_valid,
   input logic rd_dm_cmd_valid
);

   logic assert_failed = 1'b0;                      // Sticky, read at the end of the run

   // Read data valid is the strobe one cycle late
   rvalid_follows_strobe: assert property (@(posedge mem_clk) disable iff (!mem_aresetn)
      $past(mem_aresetn) |-> (reg_rvalid == $past(reg_rd)))
      else begin
         $error("reg_rvalid is not reg_rd delayed by one cycle");
         assert_failed = 1'b1;
      end

   rvalid_low_after_reset: assert property (@(posedge mem_clk) !mem_aresetn |=> !reg_rvalid)
      else begin
         $error("reg_rvalid is high in the cycle after reset");
         assert_failed = 1'b1;
      end

   // Command valid has no latency in either direction
   wr_valid_passthrough: assert property (@(posedge mem_clk) wr_dm_cmd_valid == wr_cmd_valid)
      else begin
         $error("wr_dm_cmd_valid differs from wr_cmd_valid");
         assert_failed = 1'b1;
      end

   rd_valid_passthrough: assert property (@(posedge mem_clk) rd_dm_cmd_valid == rd_cmd_valid)
      else begin
         $error("rd_dm_cmd_valid differs from rd_cmd_valid");
         assert_failed = 1'b1;
      end

endmodule

bind mem_single_inf mem_single_inf_asserts u_asserts (
   .mem_clk         (mem_clk),
   .mem_aresetn     (mem_aresetn),
   .reg_rd          (reg_rd),
   .reg_rvalid      (reg_rvalid),
   .wr_cmd_valid    (wr_cmd_valid),
   .wr_dm_cmd_valid (wr_dm_cmd_valid),
   .rd_cmd_valid    (rd_cmd_valid),
   .rd_dm_cmd_valid (rd_dm_cmd_valid)
);

// File: tests/tb_mem_single_inf.sv
`timescale 1ns/1ps

module tb_mem_single_inf
   import mem_stats_pkg::*;
();

   logic                  mem_clk;
   logic                  mem_aresetn     = 1'b0;
   logic                  wr_cmd_valid    = 1'b0;
   logic [ADDR_W-1:0]     wr_cmd_addr     = '0;
   logic [BTT_W-1:0]      wr_cmd_len      = '0;
   logic                  wr_dm_cmd_ready = 1'b0;
   logic                  rd_cmd_valid    = 1'b0;
   logic [ADDR_W-1:0]     rd_cmd_addr     = '0;
   logic [BTT_W-1:0]      rd_cmd_len      = '0;
   logic                  rd_dm_cmd_ready = 1'b0;
   logic                  wr_data_valid   = 1'b0;
   logic                  wr_data_ready   = 1'b0;
   logic [KEEP_W-1:0]     wr_data_keep    = '0;
   logic                  wr_data_last    = 1'b0;
   logic                  rd_data_valid   = 1'b0;
   logic                  rd_data_ready   = 1'b0;
   logic [KEEP_W-1:0]     rd_data_keep    = '0;
   logic                  rd_data_last    = 1'b0;
   logic                  wr_sts_valid    = 1'b0;
   logic                  wr_sts_ready    = 1'b0;
   logic [STS_W-1:0]      wr_sts_data     = '0;
   logic                  rd_sts_valid    = 1'b0;
   logic                  rd_sts_ready    = 1'b0;
   logic [STS_W-1:0]      rd_sts_data     = '0;
   logic                  reg_rd          = 1'b0;
   logic [REG_ADDR_W-1:0] reg_addr        = '0;
   logic                  wr_cmd_ready;
   logic                  wr_dm_cmd_valid;
   logic [CMD_W-1:0]      wr_dm_cmd_data;
   logic                  rd_cmd_ready;
   logic                  rd_dm_cmd_valid;
   logic [CMD_W-1:0]      rd_dm_cmd_data;
   logic                  reg_rvalid;
   logic [REG_W-1:0]      reg_rdata;
   logic [15:0]           lfsr_state;

   mem_single_inf dut0 (.*);

   initial begin
      mem_clk = 1'b0;
      forever #10 mem_clk = ~mem_clk;
   end

   // x^16 + x^14 + x^13 + x^11, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
         lfsr_state = {lfsr_state[14:0], fb};
         val        = {val[30:0], fb};
      end
      return val;
   endfunction

   // Field positions taken bit by bit from the command word layout
   function automatic logic [CMD_W-1:0] expected_cmd_word(input logic [ADDR_W-1:0] addr,
                                                          input logic [BTT_W-1:0] len);
      logic [CMD_W-1:0] word;
      word        = '0;
      word[22:0]  = len;
      word[23]    = 1'b1;                           // type
      word[30]    = 1'b1;                           // eof
      word[31]    = 1'b1;                           // drr
      word[63:32] = addr;
      return word;
   endfunction

   task automatic stop_run();
      $display("STATUS: FAIL");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [71:0] got,
                              input logic [71:0] exp);
      assert (got === exp) else begin
         $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output logic [REG_W-1:0] data);
      int waited;
      waited = 0;
      @(posedge mem_clk);
      reg_rd   <= 1'b1;
      reg_addr <= addr;
      @(posedge mem_clk);
      reg_rd <= 1'b0;
      @(negedge mem_clk);
      while (!reg_rvalid) begin
         waited++;
         assert (waited <= 8) else begin
            $display("Timed out waiting for reg_rvalid after a read strobe");
            stop_run();
         end
         @(negedge mem_clk);
      end
      data = reg_rdata;
   endtask

   task automatic check_reg(input logic [REG_ADDR_W-1:0] addr, input logic [REG_W-1:0] exp);
      logic [REG_W-1:0] data;
      read_reg(addr, data);
      check_value($sformatf("reg_rdata at address %0d", addr), data, exp);
   endtask

   task automatic test_reset_values();
      for (int a = 0; a < 16; a++) begin
         if (a % 8 < 6) begin
            check_reg(a, '0);
         end
      end
   endtask

   task automatic test_commands();
      int wr_fires;
      int rd_fires;
      wr_fires = 0;
      rd_fires = 0;
      for (int i = 0; i < 20; i++) begin
         @(posedge mem_clk);
         wr_cmd_valid    <= rand_bits(1);
         wr_dm_cmd_ready <= rand_bits(1);
         wr_cmd_addr     <= rand_bits(ADDR_W);
         wr_cmd_len      <= rand_bits(BTT_W);
         rd_cmd_valid    <= rand_bits(1);
         rd_dm_cmd_ready <= rand_bits(1);
         rd_cmd_addr     <= rand_bits(ADDR_W);
         rd_cmd_len      <= rand_bits(BTT_W);
         @(negedge mem_clk);
         check_value("wr_dm_cmd_data", wr_dm_cmd_data, expected_cmd_word(wr_cmd_addr, wr_cmd_len));
         check_value("rd_dm_cmd_data", rd_dm_cmd_data, expected_cmd_word(rd_cmd_addr, rd_cmd_len));
         check_value("wr_cmd_ready", wr_cmd_ready, wr_dm_cmd_ready);
         check_value("rd_cmd_ready", rd_cmd_ready, rd_dm_cmd_ready);
         if (wr_cmd_valid && wr_dm_cmd_ready) wr_fires++;   // Counted at the next edge
         if (rd_cmd_valid && rd_dm_cmd_ready) rd_fires++;
      end
      @(posedge mem_clk);
      wr_cmd_valid <= 1'b0;
      rd_cmd_valid <= 1'b0;
      check_reg(REG_WR_CMD, wr_fires);
      check_reg(REG_RD_CMD, rd_fires);
   endtask

   task automatic test_stream(input bit rd_side);
      logic              v;
      logic              r;
      logic              l;
      logic [KEEP_W-1:0] keep;
      int                k;
      int                words;
      int                pkgs;
      longint            bytes;
      words = 0;
      pkgs  = 0;
      bytes = 0;
      for (int i = 0; i < 24; i++) begin
         v    = rand_bits(1);
         r    = rand_bits(1);
         l    = rand_bits(1);
         k    = rand_bits(3) + 1;
         keep = ~({KEEP_W{1'b1}} << (KEEP_GRAIN * k));
         if (i % 6 == 5) begin
            keep = 64'h0000_00FF_0000_FFFF;         // Gap in the mask, worth no bytes
            k    = 0;
            v    = 1'b1;
            r    = 1'b1;
         end
         @(posedge mem_clk);
         if (rd_side) begin
            rd_data_valid <= v;
            rd_data_ready <= r;
            rd_data_keep  <= keep;
            rd_data_last  <= l;
         end else begin
            wr_data_valid <= v;
            wr_data_ready <= r;
            wr_data_keep  <= keep;
            wr_data_last  <= l;
         end
         if (v && r) begin
            words++;
            bytes += KEEP_GRAIN * k;
            if (l) pkgs++;
         end
      end
      @(posedge mem_clk);
      wr_data_valid <= 1'b0;
      rd_data_valid <= 1'b0;
      check_reg(rd_side ? REG_RD_WORD : REG_WR_WORD, words);
      check_reg(rd_side ? REG_RD_PKG : REG_WR_PKG, pkgs);
      check_reg(rd_side ? REG_RD_LEN : REG_WR_LEN, bytes);
   endtask

   task automatic test_status();
      int wr_cnt;
      int wr_err;
      int rd_cnt;
      int rd_err;
      wr_cnt = 0;
      wr_err = 0;
      rd_cnt = 0;
      rd_err = 0;
      for (int i = 0; i < 24; i++) begin
         @(posedge mem_clk);
         wr_sts_valid <= rand_bits(1);
         wr_sts_ready <= rand_bits(1);
         wr_sts_data  <= rand_bits(STS_W);
         rd_sts_valid <= rand_bits(1);
         rd_sts_ready <= rand_bits(1);
         rd_sts_data  <= rand_bits(STS_W);
         @(negedge mem_clk);
         if (wr_sts_valid && wr_sts_ready) begin
            wr_cnt++;
            if (!wr_sts_data[7]) wr_err++;          // okay bit clear
         end
         if (rd_sts_valid && rd_sts_ready) begin
            rd_cnt++;
            if (!rd_sts_data[7]) rd_err++;
         end
      end
      @(posedge mem_clk);
      wr_sts_valid <= 1'b0;
      rd_sts_valid <= 1'b0;
      check_reg(REG_WR_STS, wr_cnt);
      check_reg(REG_WR_STS_ERR, wr_err);
      check_reg(REG_RD_STS, rd_cnt);
      check_reg(REG_RD_STS_ERR, rd_err);
   endtask

   task automatic test_unmapped();
      check_reg(4'd6, '0);
      check_reg(4'd7, '0);
      check_reg(4'd14, '0);
      check_reg(4'd15, '0);
   endtask

   initial begin
      lfsr_state = 16'd37014;
      repeat (2) @(posedge mem_clk);
      mem_aresetn <= 1'b1;
      test_reset_values();
      test_commands();
      test_stream(1'b0);
      test_stream(1'b1);
      test_status();
      test_unmapped();
      if (dut0.u_asserts.assert_failed) begin
         $display("A bound assertion failed during the run");
         stop_run();
      end else begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

// File: sources.f
logic/mem_stats_pkg.sv
logic/mem_cmd_formatter.sv
logic/mem_stream_meter.sv
logic/mem_status_tracker.sv
logic/mem_stats_regs.sv
logic/mem_single_inf.sv
tests/mem_single_inf_asserts.sv
tests/tb_mem_single_inf.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the mem_single_inf testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_single_inf \
   -f sources.f -o tb_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulator exited with an error status"
grep -q "STATUS: FAIL" sim.log && { echo "Test failed, see sim.log"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Test passed"
